// File: vlog.f
rtl/coherencePkg.sv
rtl/snoopCache.sv
rtl/busArbiter.sv
rtl/mainMemory.sv
rtl/coherenceSystem.sv
verification/coherenceAssert_assert.sv
verification/tbCoherence.sv

// File: run.sh
#!/bin/sh
# compile and run the coherence testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tbCoherence -f vlog.f -o simCoherence

status=0
./obj_dir/simCoherence > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -q "^Result: PASSED$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// File: verification/tbCoherence.sv
`timescale 1ns/100ps

module tbCoherence;
	import coherencePkg::*;

	localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH;
	localparam int LINES = 1 << INDEX_WIDTH;
	localparam int DEPTH = 1 << ADDR_WIDTH;
	localparam int TIMEOUT = 200; // cycles per wait
	localparam int RANDOM_REQUESTS = 400;

	logic clock;
	logic rst;
	logic reqValid;
	logic [ID_WIDTH-1:0] reqCpu;
	logic reqWrite;
	logic [ADDR_WIDTH-1:0] reqAddress;
	logic [DATA_WIDTH-1:0] reqData;
	logic reqReady;
	logic respValid;
	logic [DATA_WIDTH-1:0] respData;
	mesiState respState;

	// reference model of every cache line and the coherent value per address
	logic [TAG_WIDTH-1:0] modelTag [NUM_CACHES][LINES];
	mesiState modelState [NUM_CACHES][LINES];
	logic [DATA_WIDTH-1:0] modelValue [DEPTH];

	logic [DATA_WIDTH-1:0] expDataQ [$];
	mesiState expStateQ [$];
	int checks;
	int dataErrors;
	int stateErrors;
	int otherErrors;
	bit hung;
	int seed;

	coherenceSystem #(
		.NUM_CACHES(NUM_CACHES),
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH),
		.INDEX_WIDTH(INDEX_WIDTH)
	) i_dut (
		.clock(clock), .rst(rst), .reqValid(reqValid), .reqCpu(reqCpu),
		.reqWrite(reqWrite), .reqAddress(reqAddress), .reqData(reqData),
		.reqReady(reqReady), .respValid(respValid), .respData(respData),
		.respState(respState)
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic logic holds(input int cpu, input logic [ADDR_WIDTH-1:0] addr);
		logic [INDEX_WIDTH-1:0] idx;
		idx = addr[INDEX_WIDTH-1:0];
		return (modelState[cpu][idx] != Invalid)
			&& (modelTag[cpu][idx] == addr[ADDR_WIDTH-1:INDEX_WIDTH]);
	endfunction

	// expected response from the model before the request is applied
	function automatic void predict(input int cpu, input logic write,
		input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data,
		output logic [DATA_WIDTH-1:0] expData, output mesiState expState);
		logic elsewhere;
		elsewhere = 1'b0;
		for (int c = 0; c < NUM_CACHES; c++)
			if (c != cpu && holds(c, addr))
				elsewhere = 1'b1;
		expData = write ? data : modelValue[addr];
		if (write)
			expState = Modified;
		else if (holds(cpu, addr))
			expState = modelState[cpu][addr[INDEX_WIDTH-1:0]]; // read hit keeps its state
		else
			expState = elsewhere ? Shared : Exclusive;
	endfunction

	function automatic void applyRequest(input int cpu, input logic write,
		input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data,
		input mesiState newState);
		logic [INDEX_WIDTH-1:0] idx;
		idx = addr[INDEX_WIDTH-1:0];
		for (int c = 0; c < NUM_CACHES; c++)
			if (c != cpu && holds(c, addr))
				modelState[c][idx] = write ? Invalid : Shared;
		if (write)
			modelValue[addr] = data;
		modelTag[cpu][idx] = addr[ADDR_WIDTH-1:INDEX_WIDTH]; // old line is evicted
		modelState[cpu][idx] = newState;
	endfunction

	task automatic compareData(input logic [DATA_WIDTH-1:0] actual,
		input logic [DATA_WIDTH-1:0] expected);
		checks++;
		if (actual !== expected)
		begin
			dataErrors++;
			$display("FAILED at %0t: respData %h, expected %h", $time, actual, expected);
		end
	endtask

	task automatic compareState(input mesiState actual, input mesiState expected);
		checks++;
		if (actual !== expected)
		begin
			stateErrors++;
			$display("FAILED at %0t: respState %s, expected %s", $time, actual.name(),
				expected.name());
		end
	endtask

	task automatic sendRequest(input int cpu, input logic write,
		input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data);
		logic [DATA_WIDTH-1:0] expData;
		mesiState expState;
		int waited;
		if (hung)
			return;
		predict(cpu, write, addr, data, expData, expState);
		applyRequest(cpu, write, addr, data, expState);
		expDataQ.push_back(expData);
		expStateQ.push_back(expState);
		reqCpu = ID_WIDTH'(cpu);
		reqWrite = write;
		reqAddress = addr;
		reqData = data;
		reqValid = 1'b1;
		waited = 0;
		while (!reqReady && waited < TIMEOUT)
		begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (!reqReady)
		begin
			hung = 1'b1;
			$display("timeout waiting for reqReady at %0t", $time);
			return;
		end
		@(posedge clock); // accepted on this edge
		#1;
		reqValid = 1'b0;
		waited = 0;
		while (!respValid && waited < TIMEOUT)
		begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (!respValid)
		begin
			hung = 1'b1;
			$display("timeout waiting for respValid at %0t", $time);
		end
	endtask

	// samples the response away from the clock edge
	initial
	begin
		logic [DATA_WIDTH-1:0] expData;
		mesiState expState;
		bit readyDue;
		readyDue = 1'b0;
		forever
		begin
			@(negedge clock);
			if (readyDue && !reqReady)
			begin
				otherErrors++;
				$display("reqReady still low at %0t in the cycle after respValid", $time);
			end
			readyDue = !rst && respValid;
			if (!rst && respValid)
			begin
				if (expDataQ.size() == 0)
				begin
					otherErrors++;
					$display("response at %0t without an outstanding request", $time);
				end
				else
				begin
					expData = expDataQ.pop_front();
					expState = expStateQ.pop_front();
					compareData(respData, expData);
					compareState(respState, expState);
				end
			end
		end
	end

	initial
	begin
		logic [31:0] r;
		int waited;
		rst = 1'b1;
		reqValid = 1'b0;
		reqCpu = '0;
		reqWrite = 1'b0;
		reqAddress = '0;
		reqData = '0;
		checks = 0;
		dataErrors = 0;
		stateErrors = 0;
		otherErrors = 0;
		hung = 1'b0;
		seed = 32'h0b7f_1418;
		for (int c = 0; c < NUM_CACHES; c++)
			for (int i = 0; i < LINES; i++)
			begin
				modelTag[c][i] = '0;
				modelState[c][i] = Invalid;
			end
		for (int a = 0; a < DEPTH; a++)
			modelValue[a] = '0;
		repeat (3) @(posedge clock);
		#1;
		rst = 1'b0;

		sendRequest(0, 1'b0, 4'h5, 4'h0); // cold miss to E
		sendRequest(0, 1'b0, 4'h5, 4'h0); // hit stays E
		sendRequest(0, 1'b1, 4'h5, 4'hA); // silent E to M
		sendRequest(1, 1'b0, 4'h5, 4'h0); // dirty supplier leaves both in S
		sendRequest(0, 1'b0, 4'h9, 4'h0);
		sendRequest(1, 1'b0, 4'hD, 4'h0);
		sendRequest(2, 1'b0, 4'h5, 4'h0); // only memory has it now
		sendRequest(0, 1'b0, 4'h6, 4'h0);
		sendRequest(1, 1'b0, 4'h6, 4'h0);
		sendRequest(0, 1'b1, 4'h6, 4'h3); // write hit in S
		sendRequest(1, 1'b0, 4'h6, 4'h0);
		sendRequest(2, 1'b1, 4'h3, 4'h7);
		sendRequest(2, 1'b1, 4'hB, 4'h2); // Modified victim written back
		sendRequest(1, 1'b0, 4'h3, 4'h0);
		sendRequest(0, 1'b0, 4'hB, 4'h0);

		for (int n = 0; n < RANDOM_REQUESTS; n++)
		begin
			r = $random(seed);
			sendRequest(int'(r[1:0]) % NUM_CACHES, r[2], r[7:4], r[11:8]);
		end

		waited = 0;
		while (expDataQ.size() != 0 && waited < TIMEOUT)
		begin
			@(posedge clock);
			waited++;
		end
		if (expDataQ.size() != 0)
		begin
			hung = 1'b1;
			$display("timeout waiting for the last responses to be checked");
		end
		$display("checks %0d, data errors %0d, state errors %0d, other errors %0d",
			checks, dataErrors, stateErrors, otherErrors);
		if (hung || (dataErrors + stateErrors + otherErrors) != 0)
			$display("Result: FAILED");
		else
			$display("Result: PASSED");
		$finish;
	end

endmodule

// File: verification/coherenceAssert_assert.sv
`timescale 1ns/100ps

module coherenceAssert (
	input logic clock,
	input logic rst,
	input logic reqValid,
	input logic reqReady,
	input logic respValid,
	input coherencePkg::mesiState respState
);
	import coherencePkg::*;

	respPulse: assert property (@(posedge clock) disable iff (rst)
		respValid |=> !respValid)
		else $error("respValid lasted more than one cycle");

	// a finished access always leaves a valid line
	respStateValid: assert property (@(posedge clock) disable iff (rst)
		respValid |-> respState != Invalid)
		else $error("respState is Invalid with respValid");

	acceptDropsReady: assert property (@(posedge clock) disable iff (rst)
		(reqValid && reqReady) |=> !reqReady)
		else $error("reqReady still high after acceptance");

	respOnlyWhenBusy: assert property (@(posedge clock) disable iff (rst)
		respValid |-> !reqReady) // response belongs to an accepted request
		else $error("respValid while reqReady is high");

endmodule

bind coherenceSystem coherenceAssert i_assert (
	.clock(clock), .rst(rst), .reqValid(reqValid), .reqReady(reqReady),
	.respValid(respValid), .respState(respState)
);

// File: rtl/coherenceSystem.sv
`timescale 1ns/100ps

module coherenceSystem #(
	parameter int NUM_CACHES = coherencePkg::NUM_CACHES,
	parameter int ADDR_WIDTH = coherencePkg::ADDR_WIDTH,
	parameter int DATA_WIDTH = coherencePkg::DATA_WIDTH,
	parameter int INDEX_WIDTH = coherencePkg::INDEX_WIDTH
) (
	input logic clock,
	input logic rst,
	input logic reqValid,
	input logic [coherencePkg::ID_WIDTH-1:0] reqCpu,
	input logic reqWrite,
	input logic [ADDR_WIDTH-1:0] reqAddress,
	input logic [DATA_WIDTH-1:0] reqData,
	output logic reqReady,
	output logic respValid,
	output logic [DATA_WIDTH-1:0] respData,
	output coherencePkg::mesiState respState
);
	import coherencePkg::*;

	logic busy;
	logic reqStart;

	logic [NUM_CACHES-1:0] cacheRespValid;
	logic [NUM_CACHES-1:0][DATA_WIDTH-1:0] cacheRespData;
	mesiState [NUM_CACHES-1:0] cacheRespState;
	busMessage [NUM_CACHES-1:0] cacheMsg;
	logic [NUM_CACHES-1:0][ADDR_WIDTH-1:0] cacheAddress;
	logic [NUM_CACHES-1:0][DATA_WIDTH-1:0] cacheData;
	logic [NUM_CACHES-1:0] cacheShared;
	logic [NUM_CACHES-1:0] cacheDirty;

	busMessage fillMsg;
	logic [ADDR_WIDTH-1:0] fillAddress;
	logic [DATA_WIDTH-1:0] fillData;

	logic [ID_WIDTH-1:0] busSource;
	busMessage busMsg;
	logic [ADDR_WIDTH-1:0] busAddress;
	logic [DATA_WIDTH-1:0] busData;
	logic busShared;
	logic busDirty;

	assign reqReady = !busy;
	assign reqStart = reqValid && reqReady; // one cycle, fields still held

	always_ff @(posedge clock)
	begin
		if (rst)
			busy <= 1'b0;
		else if (reqStart)
			busy <= 1'b1;
		else if (respValid)
			busy <= 1'b0;
	end

	// only the owning cache answers, the rest are masked out
	always_comb
	begin
		logic [DATA_WIDTH-1:0] dataOr;
		logic [$bits(mesiState)-1:0] stateOr;
		dataOr = '0;
		stateOr = '0;
		for (int i = 0; i < NUM_CACHES; i++)
		begin
			if (cacheRespValid[i])
			begin
				dataOr = dataOr | cacheRespData[i];
				stateOr = stateOr | cacheRespState[i];
			end
		end
		respValid = |cacheRespValid;
		respData = dataOr;
		respState = mesiState'(stateOr);
	end

	for (genvar c = 0; c < NUM_CACHES; c++)
	begin : cacheSlot
		snoopCache #(
			.CACHE_ID(c),
			.ADDR_WIDTH(ADDR_WIDTH),
			.DATA_WIDTH(DATA_WIDTH),
			.INDEX_WIDTH(INDEX_WIDTH)
		) i_cache (
			.clock(clock), .rst(rst), .reqStart(reqStart), .reqCpu(reqCpu),
			.reqWrite(reqWrite), .reqAddress(reqAddress), .reqData(reqData),
			.busSource(busSource), .busMsg(busMsg), .busAddress(busAddress),
			.busData(busData), .busShared(busShared), .busDirty(busDirty),
			.respValid(cacheRespValid[c]), .respData(cacheRespData[c]),
			.respState(cacheRespState[c]), .outMsg(cacheMsg[c]),
			.outAddress(cacheAddress[c]), .outData(cacheData[c]),
			.outShared(cacheShared[c]), .outDirty(cacheDirty[c])
		);
	end

	busArbiter #(
		.NUM_CACHES(NUM_CACHES),
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH)
	) i_arbiter (
		.clock(clock), .rst(rst), .cacheMsg(cacheMsg), .cacheAddress(cacheAddress),
		.cacheData(cacheData), .cacheShared(cacheShared), .cacheDirty(cacheDirty),
		.fillMsg(fillMsg), .fillAddress(fillAddress), .fillData(fillData),
		.busSource(busSource), .busMsg(busMsg), .busAddress(busAddress),
		.busData(busData), .busShared(busShared), .busDirty(busDirty)
	);

	mainMemory #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH)
	) i_memory (
		.clock(clock), .rst(rst), .busMsg(busMsg), .busAddress(busAddress),
		.busData(busData), .busDirty(busDirty), .fillMsg(fillMsg),
		.fillAddress(fillAddress), .fillData(fillData)
	);

endmodule

// File: rtl/mainMemory.sv
`timescale 1ns/100ps

module mainMemory #(
	parameter int ADDR_WIDTH = coherencePkg::ADDR_WIDTH,
	parameter int DATA_WIDTH = coherencePkg::DATA_WIDTH
) (
	input logic clock,
	input logic rst,
	input coherencePkg::busMessage busMsg,
	input logic [ADDR_WIDTH-1:0] busAddress,
	input logic [DATA_WIDTH-1:0] busData,
	input logic busDirty,
	output coherencePkg::busMessage fillMsg,
	output logic [ADDR_WIDTH-1:0] fillAddress,
	output logic [DATA_WIDTH-1:0] fillData
);
	import coherencePkg::*;

	localparam int DEPTH = 1 << ADDR_WIDTH;

	logic [DATA_WIDTH-1:0] memArray [DEPTH];
	logic writeEnable;

	// victim write-back, or a snooper handing over modified data
	assign writeEnable = (busMsg == WriteBack) || ((busMsg == Fill) && busDirty);

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			fillMsg <= None;
			for (int i = 0; i < DEPTH; i++)
				memArray[i] <= '0;
		end
		else
		begin
			if (writeEnable)
				memArray[busAddress] <= busData;
			if (busMsg == ReadMiss)
			begin
				fillMsg <= Fill; // loses to any cache Fill at the arbiter
				fillAddress <= busAddress;
				fillData <= memArray[busAddress];
			end
			else
			begin
				fillMsg <= None;
			end
		end
	end

endmodule

// File: rtl/busArbiter.sv
`timescale 1ns/100ps

module busArbiter #(
	parameter int NUM_CACHES = coherencePkg::NUM_CACHES,
	parameter int ADDR_WIDTH = coherencePkg::ADDR_WIDTH,
	parameter int DATA_WIDTH = coherencePkg::DATA_WIDTH
) (
	input logic clock,
	input logic rst,
	input coherencePkg::busMessage [NUM_CACHES-1:0] cacheMsg,
	input logic [NUM_CACHES-1:0][ADDR_WIDTH-1:0] cacheAddress,
	input logic [NUM_CACHES-1:0][DATA_WIDTH-1:0] cacheData,
	input logic [NUM_CACHES-1:0] cacheShared,
	input logic [NUM_CACHES-1:0] cacheDirty,
	input coherencePkg::busMessage fillMsg,
	input logic [ADDR_WIDTH-1:0] fillAddress,
	input logic [DATA_WIDTH-1:0] fillData,
	output logic [coherencePkg::ID_WIDTH-1:0] busSource,
	output coherencePkg::busMessage busMsg,
	output logic [ADDR_WIDTH-1:0] busAddress,
	output logic [DATA_WIDTH-1:0] busData,
	output logic busShared,
	output logic busDirty
);
	import coherencePkg::*;

	localparam logic [ID_WIDTH-1:0] MEMORY_ID = ID_WIDTH'(NUM_CACHES);

	logic [ID_WIDTH-1:0] nextSource;
	busMessage nextMsg;
	logic [ADDR_WIDTH-1:0] nextAddress;
	logic [DATA_WIDTH-1:0] nextData;
	logic nextShared;
	logic nextDirty;

	// memory is the fallback, caches override from the top index down
	always_comb
	begin
		nextSource = MEMORY_ID;
		nextMsg = fillMsg; // None when memory has nothing either
		nextAddress = fillAddress;
		nextData = fillData;
		nextShared = 1'b0;
		nextDirty = 1'b0;
		for (int i = NUM_CACHES - 1; i >= 0; i--)
		begin
			if (cacheMsg[i] != None)
			begin
				nextSource = ID_WIDTH'(i);
				nextMsg = cacheMsg[i];
				nextAddress = cacheAddress[i];
				nextData = cacheData[i];
				nextShared = cacheShared[i];
				nextDirty = cacheDirty[i];
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			busMsg <= None;
			busSource <= '0;
		end
		else
		begin
			busMsg <= nextMsg;
			busSource <= nextSource;
			busAddress <= nextAddress;
			busData <= nextData;
			busShared <= nextShared;
			busDirty <= nextDirty;
		end
	end

endmodule

// File: rtl/snoopCache.sv
`timescale 1ns/100ps

module snoopCache #(
	parameter int CACHE_ID = 0,
	parameter int ADDR_WIDTH = coherencePkg::ADDR_WIDTH,
	parameter int DATA_WIDTH = coherencePkg::DATA_WIDTH,
	parameter int INDEX_WIDTH = coherencePkg::INDEX_WIDTH
) (
	input logic clock,
	input logic rst,
	input logic reqStart,
	input logic [coherencePkg::ID_WIDTH-1:0] reqCpu,
	input logic reqWrite,
	input logic [ADDR_WIDTH-1:0] reqAddress,
	input logic [DATA_WIDTH-1:0] reqData,
	input logic [coherencePkg::ID_WIDTH-1:0] busSource,
	input coherencePkg::busMessage busMsg,
	input logic [ADDR_WIDTH-1:0] busAddress,
	input logic [DATA_WIDTH-1:0] busData,
	input logic busShared,
	input logic busDirty,
	output logic respValid,
	output logic [DATA_WIDTH-1:0] respData,
	output coherencePkg::mesiState respState,
	output coherencePkg::busMessage outMsg,
	output logic [ADDR_WIDTH-1:0] outAddress,
	output logic [DATA_WIDTH-1:0] outData,
	output logic outShared,
	output logic outDirty
);
	import coherencePkg::*;

	localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH;
	localparam int LINES = 1 << INDEX_WIDTH;
	localparam logic [ID_WIDTH-1:0] MY_ID = ID_WIDTH'(CACHE_ID);

	typedef enum logic [1:0]
	{
		idle,
		writeBack, // victim on its way to memory
		miss, // WriteMiss or Invalidate going out
		waitFill
	} ctrlState;

	logic [TAG_WIDTH-1:0] tagArray [LINES];
	logic [DATA_WIDTH-1:0] dataArray [LINES];
	mesiState stateArray [LINES];

	ctrlState ctrl;
	logic reqWriteQ;
	logic [ADDR_WIDTH-1:0] reqAddressQ;
	logic [DATA_WIDTH-1:0] reqDataQ;

	logic [INDEX_WIDTH-1:0] reqIndex;
	logic [INDEX_WIDTH-1:0] busIndex;
	logic [INDEX_WIDTH-1:0] heldIndex;
	logic [TAG_WIDTH-1:0] reqTag;
	logic [TAG_WIDTH-1:0] busTag;
	logic [TAG_WIDTH-1:0] heldTag;
	logic mine;
	logic reqHit;
	logic victimDirty;
	logic snoopHit;
	logic fillSeen;
	mesiState fillState;

	assign reqIndex = reqAddress[INDEX_WIDTH-1:0];
	assign reqTag = reqAddress[ADDR_WIDTH-1:INDEX_WIDTH];
	assign busIndex = busAddress[INDEX_WIDTH-1:0];
	assign busTag = busAddress[ADDR_WIDTH-1:INDEX_WIDTH];
	assign heldIndex = reqAddressQ[INDEX_WIDTH-1:0];
	assign heldTag = reqAddressQ[ADDR_WIDTH-1:INDEX_WIDTH];

	assign mine = reqStart && (reqCpu == MY_ID) && (ctrl == idle);
	assign reqHit = (stateArray[reqIndex] != Invalid) && (tagArray[reqIndex] == reqTag);
	assign victimDirty = (stateArray[reqIndex] == Modified) && !reqHit;

	// someone else's message that touches a line we hold
	assign snoopHit = (busMsg != None) && (busSource != MY_ID)
		&& (stateArray[busIndex] != Invalid) && (tagArray[busIndex] == busTag);

	assign fillSeen = (busMsg == Fill) && (busSource != MY_ID) && (busAddress == reqAddressQ);
	// dirty data also means a live copy stays elsewhere
	assign fillState = (busShared || busDirty) ? Shared : Exclusive;

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			ctrl <= idle;
			respValid <= 1'b0;
			outMsg <= None;
			for (int i = 0; i < LINES; i++)
				stateArray[i] <= Invalid;
		end
		else
		begin
			respValid <= 1'b0;
			outMsg <= None; // every message is a one-cycle pulse

			if (snoopHit)
			begin
				case (busMsg)
					ReadMiss:
					begin
						outMsg <= Fill;
						outAddress <= busAddress;
						outData <= dataArray[busIndex];
						outShared <= 1'b1;
						outDirty <= (stateArray[busIndex] == Modified);
						stateArray[busIndex] <= Shared;
					end
					WriteMiss, Invalidate:
						stateArray[busIndex] <= Invalid;
					default:
						;
				endcase
			end

			case (ctrl)
				idle:
				begin
					if (mine)
					begin
						reqWriteQ <= reqWrite;
						reqAddressQ <= reqAddress;
						reqDataQ <= reqData;
						outShared <= 1'b0;
						outDirty <= 1'b0;
						if (reqHit && !(reqWrite && stateArray[reqIndex] == Shared))
						begin
							respValid <= 1'b1;
							if (reqWrite)
							begin
								// E upgrades to M without bus traffic
								dataArray[reqIndex] <= reqData;
								stateArray[reqIndex] <= Modified;
								respData <= reqData;
								respState <= Modified;
							end
							else
							begin
								respData <= dataArray[reqIndex];
								respState <= stateArray[reqIndex];
							end
						end
						else if (reqHit)
						begin
							outMsg <= Invalidate; // write hit in S
							outAddress <= reqAddress;
							outData <= reqData;
							ctrl <= miss;
						end
						else if (victimDirty)
						begin
							outMsg <= WriteBack;
							outAddress <= {tagArray[reqIndex], reqIndex};
							outData <= dataArray[reqIndex];
							outDirty <= 1'b1;
							ctrl <= writeBack;
						end
						else
						begin
							outMsg <= reqWrite ? WriteMiss : ReadMiss;
							outAddress <= reqAddress;
							outData <= reqData;
							ctrl <= reqWrite ? miss : waitFill;
						end
					end
				end
				writeBack:
				begin
					stateArray[heldIndex] <= Invalid;
					outMsg <= reqWriteQ ? WriteMiss : ReadMiss;
					outAddress <= reqAddressQ;
					outData <= reqDataQ;
					outDirty <= 1'b0;
					ctrl <= reqWriteQ ? miss : waitFill;
				end
				miss:
				begin
					// arbiter registers our message on this edge, nothing competes
					tagArray[heldIndex] <= heldTag;
					dataArray[heldIndex] <= reqDataQ;
					stateArray[heldIndex] <= Modified;
					respValid <= 1'b1;
					respData <= reqDataQ;
					respState <= Modified;
					ctrl <= idle;
				end
				waitFill:
				begin
					if (fillSeen)
					begin
						tagArray[heldIndex] <= heldTag;
						dataArray[heldIndex] <= busData;
						stateArray[heldIndex] <= fillState;
						respValid <= 1'b1;
						respData <= busData;
						respState <= fillState;
						ctrl <= idle;
					end
				end
			endcase
		end
	end

endmodule

// File: rtl/coherencePkg.sv
package coherencePkg;

	parameter int ADDR_WIDTH = 4;
	parameter int DATA_WIDTH = 4;
	parameter int INDEX_WIDTH = 2; // low address bits select the line
	parameter int NUM_CACHES = 3;

	// one id per cache plus one for memory
	parameter int ID_WIDTH = $clog2(NUM_CACHES + 1);

	typedef enum logic [1:0]
	{
		Invalid = 2'b00,
		Shared = 2'b01,
		Exclusive = 2'b10,
		Modified = 2'b11
	} mesiState;

	// snoop bus message kinds
	typedef enum logic [2:0]
	{
		None = 3'd0,
		ReadMiss = 3'd1,
		WriteMiss = 3'd2,
		Invalidate = 3'd3,
		WriteBack = 3'd4, // dirty victim leaving a cache
		Fill = 3'd5 // data answering a ReadMiss
	} busMessage;

endpackage
